/* compile.f */
design/cnn_host_pkg.sv
design/pipe_fifo.sv
design/block_mover.sv
design/command_sequencer.sv
design/host_bridge_top.sv
verification/host_bridge_checker.sv
verification/tb_host_bridge.sv

/* design/block_mover.sv */
module block_mover import cnn_host_pkg::*; #(
	parameter int SCRATCH_WORDS = 256
) (
	input  logic       okClk,
	input  logic       i_reset,
	input  host_ctrl_t i_host_ctrl,
	input  word_t      i_in_word,
	input  logic       i_in_valid,
	output logic       o_in_pop,
	output logic       o_out_push,
	output word_t      o_out_word,
	input  logic       i_out_full,
	input  logic       i_out_two_free,
	input  logic       i_fetch_req,
	output logic       o_fetch_ack,
	output word_t      o_cmd_word,
	output logic       o_cmd_word_valid
);

	localparam int IDX_W = $clog2(SCRATCH_WORDS);
	localparam int FC_W  = $clog2(CMD_WORDS + 1);

	word_t           scratch [SCRATCH_WORDS];    // stands in for DDR2 port 0
	saddr_t          wr_addr;
	saddr_t          rd_addr;
	saddr_t          fetch_addr;
	saddr_t          rd_sel;
	logic            writes_q;
	logic            reads_q;
	logic            writes_on;
	logic            reads_on;
	logic [FC_W-1:0] fetch_cnt;
	logic            fetch_issue;
	logic            out_issue;
	logic            rd_issue;
	logic            rd_valid_q;
	logic            rd_fetch_q;                 // tag for a word bound to the sequencer
	logic            rd_last_q;
	word_t           rd_data_q;

	// --------------------------------------------------
	// write path from pipe-in to scratch
	// --------------------------------------------------
	assign writes_on = i_host_ctrl.writes_en && writes_q;   // address loads on the first cycle
	assign o_in_pop  = writes_on && i_in_valid;

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			writes_q <= 1'b0;
			wr_addr  <= '0;
		end else begin
			writes_q <= i_host_ctrl.writes_en;
			if (i_host_ctrl.writes_en && !writes_q) begin
				wr_addr <= i_host_ctrl.xfer_addr;
			end else if (o_in_pop) begin
				wr_addr <= wr_addr + 16'd1;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (o_in_pop) begin
			scratch[wr_addr[IDX_W-1:0]] <= i_in_word;
		end
	end

	// --------------------------------------------------
	// read path shared by command fetch and pipe-out
	// --------------------------------------------------
	assign reads_on    = i_host_ctrl.reads_en && reads_q;
	assign fetch_issue = i_fetch_req && (fetch_cnt != FC_W'(CMD_WORDS));  // fetch wins the port
	assign out_issue   = reads_on && i_out_two_free && !fetch_issue;
	assign rd_issue    = fetch_issue || out_issue;
	assign fetch_addr  = i_host_ctrl.cmd_addr + saddr_t'(fetch_cnt);
	assign rd_sel      = fetch_issue ? fetch_addr : rd_addr;

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			reads_q     <= 1'b0;
			rd_addr     <= '0;
			fetch_cnt   <= '0;
			rd_valid_q  <= 1'b0;
			rd_fetch_q  <= 1'b0;
			rd_last_q   <= 1'b0;
			o_fetch_ack <= 1'b0;
		end else begin
			reads_q <= i_host_ctrl.reads_en;
			if (i_host_ctrl.reads_en && !reads_q) begin
				rd_addr <= i_host_ctrl.xfer_addr;
			end else if (out_issue) begin
				rd_addr <= rd_addr + 16'd1;
			end
			if (!i_fetch_req) begin
				fetch_cnt <= '0;                     // ready for the next request
			end else if (fetch_issue) begin
				fetch_cnt <= fetch_cnt + 1'b1;
			end
			rd_valid_q <= rd_issue;
			rd_fetch_q <= fetch_issue;
			rd_last_q  <= fetch_issue && (fetch_cnt == FC_W'(CMD_WORDS - 1));
			if (!i_fetch_req) begin
				o_fetch_ack <= 1'b0;
			end else if (rd_last_q) begin
				o_fetch_ack <= 1'b1;                 // last command word went out
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (rd_issue) begin
			rd_data_q <= scratch[rd_sel[IDX_W-1:0]];
		end
	end

	assign o_out_push       = rd_valid_q && !rd_fetch_q;
	assign o_out_word       = rd_data_q;
	assign o_cmd_word_valid = rd_valid_q && rd_fetch_q;
	assign o_cmd_word       = rd_data_q;

	// every pipe-out word lands in room
	a_push_not_full : assert property (@(posedge okClk) disable iff (i_reset)
		o_out_push |-> !i_out_full);

endmodule

/* design/cnn_host_pkg.sv */
package cnn_host_pkg;

	// --------------------------------------------------
	// basic word and address types
	// --------------------------------------------------
	typedef logic [31:0] word_t;        // one pipe or scratch word
	typedef logic [15:0] saddr_t;       // scratch word address
	typedef logic [29:0] dram_addr_t;   // engine side address field

	localparam int CMD_WORDS = 8;       // words in one layer command

	// codes 4..7 are not defined and rejected by the sequencer
	typedef enum logic [2:0] {
		OP_NONE    = 3'd0,
		OP_CONV    = 3'd1,
		OP_MAXPOOL = 3'd2,
		OP_AVEPOOL = 3'd3
	} op_type_e;

	// --------------------------------------------------
	// host control word
	// --------------------------------------------------
	typedef struct packed {
		logic   reads_en;               // scratch -> pipe-out
		logic   writes_en;              // pipe-in -> scratch
		logic   op_en;                  // start one layer command
		saddr_t xfer_addr;              // start address of a block transfer
		saddr_t cmd_addr;               // address of the 8-word command
	} host_ctrl_t;

	// --------------------------------------------------
	// unpacked layer command, 256 bits
	// --------------------------------------------------
	typedef struct packed {
		logic [2:0]  op_type;
		logic [3:0]  stride;
		logic [7:0]  kernel;
		logic [7:0]  i_side;
		logic [7:0]  o_side;
		logic [15:0] i_channel;
		logic [15:0] o_channel;
		logic [1:0]  result_mask;
		logic [7:0]  kernel_size;
		logic [15:0] stride2;
		dram_addr_t  data_start;
		dram_addr_t  weight_start;
		dram_addr_t  p0_result_start;
		dram_addr_t  p1_result_start;
		logic [7:0]  p0_pad_head;
		logic [7:0]  p0_pad_body;
		logic [7:0]  p1_pad_head;
		logic [7:0]  p1_pad_body;
		logic [14:0] spare;             // rounds the struct out to 256
	} layer_cmd_t;

	// word slots of a command in scratch, in address order
	localparam int CW_SHAPE     = 0;    // op, stride, kernel, sides
	localparam int CW_CHANNEL   = 1;    // i_channel low, o_channel high
	localparam int CW_MISC      = 2;    // result_mask, kernel_size, stride2
	localparam int CW_WEIGHT    = 3;
	localparam int CW_DATA      = 4;
	localparam int CW_P0_RESULT = 5;
	localparam int CW_P1_RESULT = 6;
	localparam int CW_PAD       = 7;    // four pad bytes, p0 head first

endpackage

/* design/command_sequencer.sv */
module command_sequencer import cnn_host_pkg::*; (
	input  logic       okClk,
	input  logic       i_reset,
	input  logic       i_op_en,
	output logic       o_fetch_req,
	input  logic       i_fetch_ack,
	input  word_t      i_cmd_word,
	input  logic       i_cmd_word_valid,
	output layer_cmd_t o_layer_cmd,
	output logic       o_engine_req,
	input  logic       i_engine_ack,
	output logic       o_irq,
	output logic       o_cmd_error
);

	localparam int IDX_W = $clog2(CMD_WORDS);

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		RELEASE,
		CHECK,
		ENGINE_REQ,
		ENGINE_WAIT,
		DONE,
		ERROR
	} state_e;

	state_e           state;
	state_e           state_nxt;
	logic             op_en_q;
	logic             op_legal;
	logic [IDX_W-1:0] word_idx;
	word_t            cmd_words [CMD_WORDS];

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:        if (i_op_en && !op_en_q) state_nxt = FETCH;
			FETCH:       if (i_fetch_ack) state_nxt = CHECK;
			CHECK:       state_nxt = op_legal ? RELEASE : ERROR;
			// both handshakes must be idle before the engine sees req
			RELEASE:     if (!i_fetch_ack && !i_engine_ack) state_nxt = ENGINE_REQ;
			ENGINE_REQ:  if (i_engine_ack) state_nxt = ENGINE_WAIT;
			ENGINE_WAIT: if (!i_engine_ack) state_nxt = DONE;
			DONE, ERROR: if (!i_op_en) state_nxt = IDLE;
			default:     state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state    <= IDLE;
			op_en_q  <= 1'b0;
			word_idx <= '0;
		end else begin
			state   <= state_nxt;
			op_en_q <= i_op_en;
			if (state == IDLE) begin
				word_idx <= '0;
			end else if (state == FETCH && i_cmd_word_valid) begin
				word_idx <= word_idx + 1'b1;        // words arrive in address order
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (state == FETCH && i_cmd_word_valid) begin
			cmd_words[word_idx] <= i_cmd_word;
		end
	end

	assign o_fetch_req  = (state == FETCH);
	assign o_engine_req = (state == ENGINE_REQ);
	assign o_irq        = (state == DONE);           // held until op_en drops
	assign o_cmd_error  = (state == ERROR);

	// --------------------------------------------------
	// command unpack, fixed word layout
	// --------------------------------------------------
	always_comb begin
		o_layer_cmd                 = '0;
		o_layer_cmd.op_type         = cmd_words[CW_SHAPE][2:0];
		o_layer_cmd.stride          = cmd_words[CW_SHAPE][7:4];    // bit 3 unused
		o_layer_cmd.kernel          = cmd_words[CW_SHAPE][15:8];
		o_layer_cmd.i_side          = cmd_words[CW_SHAPE][23:16];
		o_layer_cmd.o_side          = cmd_words[CW_SHAPE][31:24];
		o_layer_cmd.i_channel       = cmd_words[CW_CHANNEL][15:0];
		o_layer_cmd.o_channel       = cmd_words[CW_CHANNEL][31:16];
		o_layer_cmd.result_mask     = cmd_words[CW_MISC][1:0];
		o_layer_cmd.kernel_size     = cmd_words[CW_MISC][15:8];
		o_layer_cmd.stride2         = cmd_words[CW_MISC][31:16];
		o_layer_cmd.weight_start    = cmd_words[CW_WEIGHT][29:0];
		o_layer_cmd.data_start      = cmd_words[CW_DATA][29:0];
		o_layer_cmd.p0_result_start = cmd_words[CW_P0_RESULT][29:0];
		o_layer_cmd.p1_result_start = cmd_words[CW_P1_RESULT][29:0];
		o_layer_cmd.p0_pad_head     = cmd_words[CW_PAD][7:0];
		o_layer_cmd.p0_pad_body     = cmd_words[CW_PAD][15:8];
		o_layer_cmd.p1_pad_head     = cmd_words[CW_PAD][23:16];
		o_layer_cmd.p1_pad_body     = cmd_words[CW_PAD][31:24];
	end

	always_comb begin
		case (o_layer_cmd.op_type)
			OP_NONE, OP_CONV, OP_MAXPOOL, OP_AVEPOOL: op_legal = 1'b1;
			default:                                  op_legal = 1'b0;
		endcase
	end

	a_cmd_stable : assert property (@(posedge okClk) disable iff (i_reset)
		o_engine_req |=> $stable(o_layer_cmd));
	a_req_after_ack_low : assert property (@(posedge okClk) disable iff (i_reset)
		$rose(o_engine_req) |-> !i_engine_ack);

endmodule

/* design/host_bridge_top.sv */
module host_bridge_top import cnn_host_pkg::*; #(
	parameter int FIFO_DEPTH    = 64,
	parameter int BLOCK_WORDS   = 16,
	parameter int HEADROOM      = 4,
	parameter int SCRATCH_WORDS = 256
) (
	input  logic       okClk,
	input  logic       i_reset,
	input  host_ctrl_t i_host_ctrl,
	input  logic       i_pipe_in_write,
	input  word_t      i_pipe_in_data,
	output logic       o_pipe_in_ready,
	input  logic       i_pipe_out_read,
	output word_t      o_pipe_out_data,
	output logic       o_pipe_out_valid,
	output logic       o_pipe_out_ready,
	output logic       o_engine_req,
	output layer_cmd_t o_layer_cmd,
	input  logic       i_engine_ack,
	output logic       o_irq,
	output logic       o_cmd_error
);

	word_t in_head;
	logic  in_valid;
	logic  in_pop;
	word_t out_word;
	logic  out_push;
	logic  out_full;
	logic  out_two_free;
	logic  fetch_req;
	logic  fetch_ack;
	word_t cmd_word;
	logic  cmd_word_valid;

	// --------------------------------------------------
	// host pipes
	// --------------------------------------------------
	pipe_fifo #(
		.FIFO_DEPTH    (FIFO_DEPTH),
		.BLOCK_WORDS   (BLOCK_WORDS),
		.HEADROOM      (HEADROOM)
	) u_pipe_in (
		.okClk         (okClk),
		.i_reset       (i_reset),
		.i_push        (i_pipe_in_write),
		.i_push_data   (i_pipe_in_data),
		.i_pop         (in_pop),
		.o_head        (in_head),
		.o_valid       (in_valid),
		.o_full        (),
		.o_two_free    (),
		.o_block_space (o_pipe_in_ready),    // host may send one more block
		.o_block_avail ()
	);

	pipe_fifo #(
		.FIFO_DEPTH    (FIFO_DEPTH),
		.BLOCK_WORDS   (BLOCK_WORDS),
		.HEADROOM      (HEADROOM)
	) u_pipe_out (
		.okClk         (okClk),
		.i_reset       (i_reset),
		.i_push        (out_push),
		.i_push_data   (out_word),
		.i_pop         (i_pipe_out_read),
		.o_head        (o_pipe_out_data),
		.o_valid       (o_pipe_out_valid),
		.o_full        (out_full),
		.o_two_free    (out_two_free),
		.o_block_space (),
		.o_block_avail (o_pipe_out_ready)    // a full block waits for the host
	);

	// --------------------------------------------------
	// scratch mover and command sequencer
	// --------------------------------------------------
	block_mover #(
		.SCRATCH_WORDS    (SCRATCH_WORDS)
	) u_block_mover (
		.okClk            (okClk),
		.i_reset          (i_reset),
		.i_host_ctrl      (i_host_ctrl),
		.i_in_word        (in_head),
		.i_in_valid       (in_valid),
		.o_in_pop         (in_pop),
		.o_out_push       (out_push),
		.o_out_word       (out_word),
		.i_out_full       (out_full),
		.i_out_two_free   (out_two_free),
		.i_fetch_req      (fetch_req),
		.o_fetch_ack      (fetch_ack),
		.o_cmd_word       (cmd_word),
		.o_cmd_word_valid (cmd_word_valid)
	);

	command_sequencer u_command_sequencer (
		.okClk            (okClk),
		.i_reset          (i_reset),
		.i_op_en          (i_host_ctrl.op_en),
		.o_fetch_req      (fetch_req),
		.i_fetch_ack      (fetch_ack),
		.i_cmd_word       (cmd_word),
		.i_cmd_word_valid (cmd_word_valid),
		.o_layer_cmd      (o_layer_cmd),
		.o_engine_req     (o_engine_req),
		.i_engine_ack     (i_engine_ack),
		.o_irq            (o_irq),
		.o_cmd_error      (o_cmd_error)
	);

endmodule

/* design/pipe_fifo.sv */
module pipe_fifo import cnn_host_pkg::*; #(
	parameter int FIFO_DEPTH  = 64,
	parameter int BLOCK_WORDS = 16,
	parameter int HEADROOM    = 4
) (
	input  logic  okClk,
	input  logic  i_reset,
	input  logic  i_push,
	input  word_t i_push_data,
	input  logic  i_pop,
	output word_t o_head,
	output logic  o_valid,
	output logic  o_full,
	output logic  o_two_free,
	output logic  o_block_space,
	output logic  o_block_avail
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	word_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// wraps at FIFO_DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign o_valid    = (count != '0);                      // show-ahead head is live
	assign o_full     = (count == CNT_W'(FIFO_DEPTH));
	assign o_two_free = (count <= CNT_W'(FIFO_DEPTH - 2));  // room for two in-flight words
	assign o_head     = mem[rd_ptr];
	assign do_push    = i_push && !o_full;                  // overflow is dropped
	assign do_pop     = i_pop && o_valid;                   // underflow is dropped

	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_data;
		end
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	// --------------------------------------------------
	// block flags, one cycle behind the count
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			o_block_space <= 1'b0;
			o_block_avail <= 1'b0;
		end else begin
			o_block_space <= (FIFO_DEPTH - int'(count)) >= (BLOCK_WORDS + HEADROOM);
			o_block_avail <= int'(count) >= BLOCK_WORDS;    // a whole block can be read out
		end
	end

	a_no_overflow : assert property (@(posedge okClk) disable iff (i_reset)
		!(i_push && o_full));
	a_no_underflow : assert property (@(posedge okClk) disable iff (i_reset)
		!(i_pop && !o_valid));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the host bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
	--top-module tb_host_bridge -o sim_host_bridge
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_host_bridge > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
	exit 0
else
	echo "pass line not found in sim.log"
	exit 1
fi

/* verification/host_bridge_checker.sv */
module host_bridge_checker import cnn_host_pkg::*; #(
	parameter int FIFO_DEPTH  = 64,
	parameter int BLOCK_WORDS = 16,
	parameter int HEADROOM    = 4
) (
	input logic       okClk,
	input logic       i_reset,
	input logic       i_in_write,
	input word_t      i_in_data,
	input logic       i_in_pop,          // mover side of pipe-in
	input logic       i_in_ready,
	input logic       i_out_push,        // mover side of pipe-out
	input logic       i_out_read,
	input word_t      i_out_data,
	input logic       i_out_valid,
	input logic       i_out_ready,
	input logic       i_engine_req,
	input layer_cmd_t i_layer_cmd,
	input logic       i_engine_ack,
	input logic       i_irq,
	input logic       i_sb_capture,
	input logic       i_illegal_phase,
	input layer_cmd_t i_exp_cmd
);

	timeunit 1ns;
	timeprecision 100ps;

	int    in_cnt;
	int    in_prev;
	int    out_cnt;
	int    out_prev;
	logic  prev_ok;
	word_t exp_q [$];
	word_t exp_word;
	int    fail_count   = 0;
	int    fail_base    = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;

	function automatic void value_fail(string name, word_t exp, word_t got);
		fail_count++;
		$display("Fail %s expected %h got %h", name, exp, got);
	endfunction

	function automatic void note_failure(string msg);
		fail_count++;
		$display("%s", msg);
	endfunction

	function automatic void check_drained();
		if (exp_q.size() != 0) begin
			note_failure($sformatf("%0d written words never left pipe-out", exp_q.size()));
		end
	endfunction

	function automatic void end_test(string name);
		if (fail_count == fail_base) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, fail_count - fail_base);
		end
		fail_base = fail_count;
	endfunction

	// --------------------------------------------------
	// occupancy model and round-trip scoreboard
	// --------------------------------------------------
	always @(posedge okClk) begin
		if (i_reset) begin
			in_cnt   <= 0;
			in_prev  <= 0;
			out_cnt  <= 0;
			out_prev <= 0;
			prev_ok  <= 1'b0;
			exp_q.delete();
		end else begin
			in_cnt   <= in_cnt + ((i_in_write && in_cnt < FIFO_DEPTH) ? 1 : 0)
				- ((i_in_pop && in_cnt > 0) ? 1 : 0);      // full push and empty pop are dropped
			out_cnt  <= out_cnt + ((i_out_push && out_cnt < FIFO_DEPTH) ? 1 : 0)
				- ((i_out_read && out_cnt > 0) ? 1 : 0);
			in_prev  <= in_cnt;
			out_prev <= out_cnt;
			prev_ok  <= 1'b1;
			if (i_sb_capture && i_in_write) begin
				exp_q.push_back(i_in_data);
			end
			if (i_out_read && i_out_valid && exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				if (exp_word != i_out_data) begin
					value_fail("o_pipe_out_data", exp_word, i_out_data);
				end
			end
		end
	end

	a_in_ready : assert property (@(posedge okClk) disable iff (i_reset)
		prev_ok |-> (i_in_ready == ((FIFO_DEPTH - in_prev) >= (BLOCK_WORDS + HEADROOM))))
		else value_fail("o_pipe_in_ready", {31'd0, !$sampled(i_in_ready)},
			{31'd0, $sampled(i_in_ready)});
	a_out_ready : assert property (@(posedge okClk) disable iff (i_reset)
		prev_ok |-> (i_out_ready == (out_prev >= BLOCK_WORDS)))
		else value_fail("o_pipe_out_ready", {31'd0, !$sampled(i_out_ready)},
			{31'd0, $sampled(i_out_ready)});
	a_out_room : assert property (@(posedge okClk) disable iff (i_reset)
		i_out_push |-> (out_cnt < FIFO_DEPTH))
		else note_failure("mover pushed a word into a full pipe-out");

	// --------------------------------------------------
	// engine handshake
	// --------------------------------------------------
	a_cmd_fields : assert property (@(posedge okClk) disable iff (i_reset)
		i_engine_req |-> (i_layer_cmd == i_exp_cmd))
		else begin
			fail_count++;
			$display("Fail o_layer_cmd expected %h got %h", $sampled(i_exp_cmd),
				$sampled(i_layer_cmd));
		end
	a_req_rise : assert property (@(posedge okClk) disable iff (i_reset)
		$rose(i_engine_req) |-> !i_engine_ack)
		else note_failure("engine req rose while ack was still high");
	a_req_hold : assert property (@(posedge okClk) disable iff (i_reset)
		$fell(i_engine_req) |-> $past(i_engine_ack))
		else note_failure("engine req dropped before the engine acknowledged");
	a_irq_late : assert property (@(posedge okClk) disable iff (i_reset)
		$rose(i_irq) |-> (!i_engine_ack && !i_engine_req))
		else note_failure("irq rose before the engine handshake closed");
	a_no_req_illegal : assert property (@(posedge okClk) disable iff (i_reset)
		i_illegal_phase |-> !i_engine_req)
		else note_failure("engine req raised for an illegal opcode");

endmodule

/* verification/tb_host_bridge.sv */
module tb_host_bridge import cnn_host_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FIFO_DEPTH  = 64;
	localparam int BLOCK_WORDS = 16;
	localparam int HEADROOM    = 4;
	localparam int TIMEOUT     = 4000;   // about twice the whole run
	localparam int WAIT_LIMIT  = 300;

	logic       okClk;
	logic       i_reset;
	host_ctrl_t host_ctrl;
	logic       pipe_in_write;
	word_t      pipe_in_data;
	logic       pipe_in_ready;
	logic       pipe_out_read;
	word_t      pipe_out_data;
	logic       pipe_out_valid;
	logic       pipe_out_ready;
	logic       engine_req;
	layer_cmd_t layer_cmd;
	logic       engine_ack;
	logic       irq;
	logic       cmd_error;
	logic       sb_capture;
	logic       illegal_phase;
	layer_cmd_t exp_cmd;
	int         cycles = 0;

	host_bridge_top i_dut (
		.okClk (okClk), .i_reset (i_reset), .i_host_ctrl (host_ctrl),
		.i_pipe_in_write (pipe_in_write), .i_pipe_in_data (pipe_in_data),
		.o_pipe_in_ready (pipe_in_ready), .i_pipe_out_read (pipe_out_read),
		.o_pipe_out_data (pipe_out_data), .o_pipe_out_valid (pipe_out_valid),
		.o_pipe_out_ready (pipe_out_ready), .o_engine_req (engine_req),
		.o_layer_cmd (layer_cmd), .i_engine_ack (engine_ack), .o_irq (irq),
		.o_cmd_error (cmd_error)
	);

	host_bridge_checker #(
		.FIFO_DEPTH (FIFO_DEPTH), .BLOCK_WORDS (BLOCK_WORDS), .HEADROOM (HEADROOM)
	) u_checker (
		.okClk (okClk), .i_reset (i_reset), .i_in_write (pipe_in_write),
		.i_in_data (pipe_in_data), .i_in_pop (i_dut.in_pop), .i_in_ready (pipe_in_ready),
		.i_out_push (i_dut.out_push), .i_out_read (pipe_out_read),
		.i_out_data (pipe_out_data), .i_out_valid (pipe_out_valid),
		.i_out_ready (pipe_out_ready), .i_engine_req (engine_req), .i_layer_cmd (layer_cmd),
		.i_engine_ack (engine_ack), .i_irq (irq), .i_sb_capture (sb_capture),
		.i_illegal_phase (illegal_phase), .i_exp_cmd (exp_cmd)
	);

	always #5 okClk = ~okClk;

	always @(posedge okClk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("run stopped after %0d cycles, a test never finished", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// fake engine raises ack 1..8 cycles after req and drops it 1..4 cycles after req falls
	always begin
		int delay;
		tick();
		if (engine_req && !engine_ack) begin
			delay = 1 + int'($urandom % 8);
			repeat (delay) tick();
			engine_ack = 1'b1;
			while (engine_req) begin
				tick();
			end
			delay = 1 + int'($urandom % 4);
			repeat (delay) tick();
			engine_ack = 1'b0;
		end
	end

	task automatic tick();
		@(posedge okClk);
		#1;
	endtask

	task automatic write_word(input word_t w);
		pipe_in_write = 1'b1;
		pipe_in_data  = w;
		tick();
		pipe_in_write = 1'b0;
	endtask

	task automatic drain_pipe_in(input string what);
		int n;
		n = 0;
		while (i_dut.u_pipe_in.o_valid && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (n >= WAIT_LIMIT) u_checker.note_failure({what, " never emptied pipe-in"});
	endtask

	task automatic start_writes(input saddr_t addr);
		host_ctrl.writes_en = 1'b0;
		tick();
		host_ctrl.xfer_addr = addr;                  // loads on the rising enable
		host_ctrl.writes_en = 1'b1;
		tick();
	endtask

	function automatic layer_cmd_t random_cmd(input logic [2:0] op);
		layer_cmd_t c;
		c                 = '0;
		c.op_type         = op;
		c.stride          = 4'($urandom);
		c.kernel          = 8'($urandom);
		c.i_side          = 8'($urandom);
		c.o_side          = 8'($urandom);
		c.i_channel       = 16'($urandom);
		c.o_channel       = 16'($urandom);
		c.result_mask     = 2'($urandom);
		c.kernel_size     = 8'($urandom);
		c.stride2         = 16'($urandom);
		c.data_start      = 30'($urandom);
		c.weight_start    = 30'($urandom);
		c.p0_result_start = 30'($urandom);
		c.p1_result_start = 30'($urandom);
		c.p0_pad_head     = 8'($urandom);
		c.p0_pad_body     = 8'($urandom);
		c.p1_pad_head     = 8'($urandom);
		c.p1_pad_body     = 8'($urandom);
		return c;
	endfunction

	// scratch image of one command word
	function automatic word_t pack_word(input layer_cmd_t c, input int idx);
		case (idx)
			0:       return {c.o_side, c.i_side, c.kernel, c.stride, 1'b0, c.op_type};
			1:       return {c.o_channel, c.i_channel};
			2:       return {c.stride2, c.kernel_size, 6'd0, c.result_mask};
			3:       return {2'b00, c.weight_start};
			4:       return {2'b00, c.data_start};
			5:       return {2'b00, c.p0_result_start};
			6:       return {2'b00, c.p1_result_start};
			default: return {c.p1_pad_body, c.p1_pad_head, c.p0_pad_body, c.p0_pad_head};
		endcase
	endfunction

	task automatic run_command(input layer_cmd_t c, input saddr_t addr);
		exp_cmd = c;
		start_writes(addr);
		for (int i = 0; i < CMD_WORDS; i++) write_word(pack_word(c, i));
		drain_pipe_in("command load");
		host_ctrl.writes_en = 1'b0;
		host_ctrl.cmd_addr  = addr;
		tick();
		host_ctrl.op_en = 1'b1;
	endtask

	initial begin
		int n;
		int stall;
		int popped;
		int quiet;
		void'($urandom(32'h67c2_e0d1));
		okClk         = 1'b0;
		i_reset       = 1'b1;
		host_ctrl     = '0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		engine_ack    = 1'b0;
		sb_capture    = 1'b0;
		illegal_phase = 1'b0;
		exp_cmd       = '0;
		repeat (2) @(posedge okClk);
		#1 i_reset = 1'b0;
		tick();

		// --------------------------------------------------
		// pipe-in flow control with the mover idle
		// --------------------------------------------------
		for (int i = 0; i < FIFO_DEPTH - BLOCK_WORDS - HEADROOM + 1; i++) write_word($urandom);
		tick();
		if (pipe_in_ready) u_checker.value_fail("o_pipe_in_ready", 32'h0, 32'h1);
		start_writes(16'h0080);                      // park the fill words in scratch
		drain_pipe_in("fill drain");
		host_ctrl.writes_en = 1'b0;
		u_checker.end_test("pipe-in flow control");

		// --------------------------------------------------
		// round trip with back-pressure
		// --------------------------------------------------
		start_writes(16'h0020);
		sb_capture = 1'b1;
		n = 0;
		while (n < 40) begin
			pipe_in_write = pipe_in_ready;
			pipe_in_data  = $urandom;
			if (pipe_in_ready) n++;
			tick();
		end
		pipe_in_write = 1'b0;
		sb_capture    = 1'b0;
		drain_pipe_in("round trip");
		host_ctrl.writes_en = 1'b0;
		tick();
		host_ctrl.xfer_addr = 16'h0020;
		host_ctrl.reads_en  = 1'b1;
		n = 0;
		while (u_checker.out_cnt < FIFO_DEPTH && n < WAIT_LIMIT) begin
			tick();                                  // host holds off until pipe-out is full
			n++;
		end
		if (u_checker.out_cnt < FIFO_DEPTH) u_checker.note_failure("pipe-out never filled up");
		popped = 0;
		stall  = 0;
		n      = 0;
		while (popped < 40 && n < 2 * WAIT_LIMIT) begin
			if (stall > 0) begin
				pipe_out_read = 1'b0;
				stall--;
			end else if ($urandom % 6 == 0) begin
				pipe_out_read = 1'b0;
				stall = 1 + int'($urandom % 8);     // host stops popping for a while
			end else begin
				pipe_out_read = pipe_out_valid;
				if (pipe_out_valid) popped++;
			end
			tick();
			n++;
		end
		pipe_out_read = 1'b0;
		if (popped < 40) u_checker.note_failure("pipe-out stopped delivering words");
		u_checker.check_drained();
		host_ctrl.reads_en = 1'b0;
		quiet = 0;
		n     = 0;
		while (quiet < 4 && n < WAIT_LIMIT) begin
			pipe_out_read = pipe_out_valid;
			quiet = pipe_out_valid ? 0 : quiet + 1;
			tick();
			n++;
		end
		pipe_out_read = 1'b0;
		u_checker.end_test("round trip and back-pressure");

		// --------------------------------------------------
		// legal command through the engine
		// --------------------------------------------------
		run_command(random_cmd(OP_CONV), 16'h0060);
		n = 0;
		while (!irq && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!irq) u_checker.note_failure("engine handshake hung, irq never rose");
		host_ctrl.op_en = 1'b0;
		repeat (3) tick();
		u_checker.end_test("command and engine handshake");

		// --------------------------------------------------
		// illegal opcode
		// --------------------------------------------------
		illegal_phase = 1'b1;
		run_command(random_cmd(3'd5), 16'h0070);
		n = 0;
		while (!cmd_error && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!cmd_error) u_checker.note_failure("cmd_error never set for opcode 5");
		repeat (5) tick();
		host_ctrl.op_en = 1'b0;
		illegal_phase   = 1'b0;
		repeat (3) tick();
		u_checker.end_test("illegal opcode");

		$display("tests passed %0d failed %0d", u_checker.tests_passed, u_checker.tests_failed);
		if (u_checker.tests_failed == 0 && u_checker.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
